// ==== source/dcache_pkg.sv ====
// cache geometry, address field widths, request opcode and controller state enums

package dcache_pkg;

  // geometry: 4 ways by 8 sets, one 64-bit word per line
  localparam int num_way = 4;
  localparam int num_idx = 8;

  // byte address layout
  localparam int addr_bits   = 32;
  localparam int offset_bits = 3;
  localparam int index_bits  = 3;
  localparam int tag_bits    = 26;

  localparam int data_bits = 64;

  // processor operation
  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } req_op_t;

  // controller FSM
  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_lookup    = 3'd1,
    st_writeback = 3'd2,
    st_fill_req  = 3'd3,
    st_fill_wait = 3'd4,
    st_install   = 3'd5,
    st_respond   = 3'd6
  } ctrl_state_t;

endpackage

// ==== source/dcache_way.sv ====
// dcache_way: one cache way with per-set valid, dirty, tag and data storage

`timescale 1ns/1ps

module dcache_way (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [dcache_pkg::addr_bits-1:0]    lookup_addr,
  input  logic                                write_en,
  input  logic [dcache_pkg::data_bits-1:0]    write_data,
  input  logic                                write_dirty,
  output logic                                hit,
  output logic [dcache_pkg::data_bits-1:0]    data,
  output logic                                victim_valid,
  output logic                                victim_dirty,
  output logic [dcache_pkg::tag_bits-1:0]     victim_tag
);

  // per-set line state
  logic [dcache_pkg::num_idx-1:0]     valid_q;
  logic [dcache_pkg::num_idx-1:0]     dirty_q;
  logic [dcache_pkg::tag_bits-1:0]    tag_q  [dcache_pkg::num_idx];
  logic [dcache_pkg::data_bits-1:0]   data_q [dcache_pkg::num_idx];

  logic [dcache_pkg::index_bits-1:0]  idx;
  logic [dcache_pkg::tag_bits-1:0]    tag;

  // address fields
  assign idx = lookup_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
  assign tag = lookup_addr[dcache_pkg::addr_bits-1 -: dcache_pkg::tag_bits];

  // lookup of the indexed set
  assign hit  = valid_q[idx] && (tag_q[idx] == tag);
  assign data = data_q[idx];

  // the indexed line, as seen by the eviction path
  assign victim_valid = valid_q[idx];
  assign victim_dirty = dirty_q[idx];
  assign victim_tag   = tag_q[idx];

  // line state bits
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (write_en) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= write_dirty;
    end
  end

  // tag and word storage
  always_ff @(posedge clock) begin
    if (write_en) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= write_data;
    end
  end

endmodule

// ==== source/dcache_array.sv ====
// dcache_array: four ways, per-set tree pseudo-LRU, hit and victim muxing

`timescale 1ns/1ps

module dcache_array (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [dcache_pkg::addr_bits-1:0]    lookup_addr,
  input  logic                                fill_en,
  input  logic                                fill_from_mem,
  input  logic [dcache_pkg::data_bits-1:0]    fill_data,
  input  logic                                fill_dirty,
  output logic                                hit,
  output logic [dcache_pkg::data_bits-1:0]    hit_data,
  output logic                                victim_valid,
  output logic                                victim_dirty,
  output logic [dcache_pkg::addr_bits-1:0]    victim_addr,
  output logic [dcache_pkg::data_bits-1:0]    victim_data
);

  // tree bits per set
  logic [dcache_pkg::num_idx-1:0]     tree_top;
  logic [dcache_pkg::num_idx-1:0]     tree_left;
  logic [dcache_pkg::num_idx-1:0]     tree_right;

  logic [dcache_pkg::index_bits-1:0]  idx;
  logic [dcache_pkg::num_way-1:0]     victim_sel;
  logic [dcache_pkg::num_way-1:0]     way_we;
  logic                               advance;

  // per-way lookup results
  logic [dcache_pkg::num_way-1:0]     way_hit;
  logic [dcache_pkg::data_bits-1:0]   way_data [dcache_pkg::num_way];
  logic [dcache_pkg::num_way-1:0]     way_valid;
  logic [dcache_pkg::num_way-1:0]     way_dirty;
  logic [dcache_pkg::tag_bits-1:0]    way_tag  [dcache_pkg::num_way];
  logic [dcache_pkg::tag_bits-1:0]    victim_tag;

  assign idx = lookup_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];

  // victim from the tree: top bit picks the half, left or right bit picks the way
  assign victim_sel[0] = !tree_top[idx] && !tree_left[idx];
  assign victim_sel[1] = !tree_top[idx] &&  tree_left[idx];
  assign victim_sel[2] =  tree_top[idx] && !tree_right[idx];
  assign victim_sel[3] =  tree_top[idx] &&  tree_right[idx];

  // only a miss-path install moves the tree, so fills go 0, 2, 1, 3
  assign advance = fill_en && fill_from_mem && !hit;

  always_ff @(posedge clock) begin
    if (reset) begin
      tree_top   <= '0;
      tree_left  <= '0;
      tree_right <= '0;
    end else if (advance) begin
      tree_top[idx] <= !tree_top[idx];
      if (tree_top[idx]) begin
        tree_right[idx] <= !tree_right[idx];
      end else begin
        tree_left[idx] <= !tree_left[idx];
      end
    end
  end

  // write the hit way, or the victim way for a new line
  always_comb begin
    for (int w = 0; w < dcache_pkg::num_way; w++) begin
      if (hit) begin
        way_we[w] = fill_en && way_hit[w];
      end else begin
        way_we[w] = fill_en && fill_from_mem && victim_sel[w];
      end
    end
  end

  for (genvar w = 0; w < dcache_pkg::num_way; w++) begin : g_way
    dcache_way i_way (
      .clock        (clock),
      .reset        (reset),
      .lookup_addr  (lookup_addr),
      .write_en     (way_we[w]),
      .write_data   (fill_data),
      .write_dirty  (fill_dirty),
      .hit          (way_hit[w]),
      .data         (way_data[w]),
      .victim_valid (way_valid[w]),
      .victim_dirty (way_dirty[w]),
      .victim_tag   (way_tag[w])
    );
  end

  // hit and victim muxes, both one-hot
  always_comb begin
    hit          = 1'b0;
    hit_data     = '0;
    victim_valid = 1'b0;
    victim_dirty = 1'b0;
    victim_tag   = '0;
    victim_data  = '0;
    for (int w = 0; w < dcache_pkg::num_way; w++) begin
      if (way_hit[w]) begin
        hit      = 1'b1;
        hit_data = way_data[w];
      end
      if (victim_sel[w]) begin
        victim_valid = way_valid[w];
        victim_dirty = way_dirty[w];
        victim_tag   = way_tag[w];
        victim_data  = way_data[w];
      end
    end
  end

  // line address of the victim, word aligned
  assign victim_addr = {victim_tag, idx, {dcache_pkg::offset_bits{1'b0}}};

endmodule

// ==== source/dcache_ctrl.sv ====
// dcache_ctrl: request latch, miss FSM, memory strobes and processor response

`timescale 1ns/1ps

module dcache_ctrl (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                req,
  input  dcache_pkg::req_op_t                 req_op,
  input  logic [dcache_pkg::addr_bits-1:0]    req_addr,
  input  logic [dcache_pkg::data_bits-1:0]    req_data,
  input  logic                                hit,
  input  logic [dcache_pkg::data_bits-1:0]    hit_data,
  input  logic                                victim_valid,
  input  logic                                victim_dirty,
  input  logic [dcache_pkg::addr_bits-1:0]    victim_addr,
  input  logic [dcache_pkg::data_bits-1:0]    victim_data,
  input  logic                                mem_rvalid,
  input  logic [dcache_pkg::data_bits-1:0]    mem_rdata,
  output logic                                busy,
  output logic                                resp_valid,
  output logic [dcache_pkg::data_bits-1:0]    resp_data,
  output logic [dcache_pkg::addr_bits-1:0]    lookup_addr,
  output logic                                fill_en,
  output logic                                fill_from_mem,
  output logic [dcache_pkg::data_bits-1:0]    fill_data,
  output logic                                fill_dirty,
  output logic                                mem_rd,
  output logic                                mem_wr,
  output logic [dcache_pkg::addr_bits-1:0]    mem_addr,
  output logic [dcache_pkg::data_bits-1:0]    mem_wdata
);

  dcache_pkg::ctrl_state_t             state;
  dcache_pkg::ctrl_state_t             state_next;

  // latched request
  dcache_pkg::req_op_t                 op_q;
  logic [dcache_pkg::addr_bits-1:0]    addr_q;
  logic [dcache_pkg::data_bits-1:0]    data_q;
  // load word, from a hit or from memory
  logic [dcache_pkg::data_bits-1:0]    word_q;

  logic                                accept;
  logic                                is_load;

  assign accept  = (state == dcache_pkg::st_idle) && req;
  assign is_load = (op_q == dcache_pkg::op_load);

  always_comb begin
    state_next    = state;
    fill_en       = 1'b0;
    fill_from_mem = 1'b0;
    fill_dirty    = 1'b0;
    fill_data     = data_q;
    case (state)
      dcache_pkg::st_idle: begin
        if (req) begin
          state_next = dcache_pkg::st_lookup;
        end
      end
      dcache_pkg::st_lookup: begin
        if (hit) begin
          // store hit rewrites the word in place and marks it dirty
          if (!is_load) begin
            fill_en    = 1'b1;
            fill_dirty = 1'b1;
          end
          state_next = dcache_pkg::st_respond;
        end else if (victim_valid && victim_dirty) begin
          state_next = dcache_pkg::st_writeback;
        end else if (is_load) begin
          state_next = dcache_pkg::st_fill_req;
        end else begin
          state_next = dcache_pkg::st_install;
        end
      end
      dcache_pkg::st_writeback: begin
        state_next = is_load ? dcache_pkg::st_fill_req : dcache_pkg::st_install;
      end
      dcache_pkg::st_fill_req: begin
        state_next = dcache_pkg::st_fill_wait;
      end
      dcache_pkg::st_fill_wait: begin
        if (mem_rvalid) begin
          state_next = dcache_pkg::st_install;
        end
      end
      dcache_pkg::st_install: begin
        // new line: clean memory word for loads, dirty store data otherwise
        fill_en       = 1'b1;
        fill_from_mem = 1'b1;
        if (is_load) begin
          fill_data = word_q;
        end else begin
          fill_dirty = 1'b1;
        end
        state_next = dcache_pkg::st_respond;
      end
      dcache_pkg::st_respond: begin
        state_next = dcache_pkg::st_idle;
      end
      default: begin
        state_next = dcache_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= dcache_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op_q   <= req_op;
      addr_q <= req_addr;
      data_q <= req_data;
    end
    if ((state == dcache_pkg::st_lookup) && hit && is_load) begin
      word_q <= hit_data;
    end else if ((state == dcache_pkg::st_fill_wait) && mem_rvalid) begin
      word_q <= mem_rdata;
    end
  end

  // array sees the request address for the whole transaction
  assign lookup_addr = addr_q;

  // memory side: write-back of the victim, then the fetch
  assign mem_wr    = (state == dcache_pkg::st_writeback);
  assign mem_rd    = (state == dcache_pkg::st_fill_req);
  assign mem_addr  = mem_wr ? victim_addr : addr_q;
  assign mem_wdata = victim_data;

  // processor side
  assign busy       = (state != dcache_pkg::st_idle);
  assign resp_valid = (state == dcache_pkg::st_respond);
  assign resp_data  = word_q;

endmodule

// ==== source/dcache_top.sv ====
// dcache_top: controller and cache array with processor and memory ports

`timescale 1ns/1ps

module dcache_top (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                req,
  input  dcache_pkg::req_op_t                 req_op,
  input  logic [dcache_pkg::addr_bits-1:0]    req_addr,
  input  logic [dcache_pkg::data_bits-1:0]    req_data,
  input  logic                                mem_rvalid,
  input  logic [dcache_pkg::data_bits-1:0]    mem_rdata,
  output logic                                busy,
  output logic                                resp_valid,
  output logic [dcache_pkg::data_bits-1:0]    resp_data,
  output logic                                mem_rd,
  output logic                                mem_wr,
  output logic [dcache_pkg::addr_bits-1:0]    mem_addr,
  output logic [dcache_pkg::data_bits-1:0]    mem_wdata
);

  // controller to array
  logic [dcache_pkg::addr_bits-1:0]    lookup_addr;
  logic                                fill_en;
  logic                                fill_from_mem;
  logic [dcache_pkg::data_bits-1:0]    fill_data;
  logic                                fill_dirty;

  // array to controller
  logic                                hit;
  logic [dcache_pkg::data_bits-1:0]    hit_data;
  logic                                victim_valid;
  logic                                victim_dirty;
  logic [dcache_pkg::addr_bits-1:0]    victim_addr;
  logic [dcache_pkg::data_bits-1:0]    victim_data;

  dcache_ctrl i_dcache_ctrl (
    .clock         (clock),
    .reset         (reset),
    .req           (req),
    .req_op        (req_op),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .hit           (hit),
    .hit_data      (hit_data),
    .victim_valid  (victim_valid),
    .victim_dirty  (victim_dirty),
    .victim_addr   (victim_addr),
    .victim_data   (victim_data),
    .mem_rvalid    (mem_rvalid),
    .mem_rdata     (mem_rdata),
    .busy          (busy),
    .resp_valid    (resp_valid),
    .resp_data     (resp_data),
    .lookup_addr   (lookup_addr),
    .fill_en       (fill_en),
    .fill_from_mem (fill_from_mem),
    .fill_data     (fill_data),
    .fill_dirty    (fill_dirty),
    .mem_rd        (mem_rd),
    .mem_wr        (mem_wr),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata)
  );

  dcache_array i_dcache_array (
    .clock         (clock),
    .reset         (reset),
    .lookup_addr   (lookup_addr),
    .fill_en       (fill_en),
    .fill_from_mem (fill_from_mem),
    .fill_data     (fill_data),
    .fill_dirty    (fill_dirty),
    .hit           (hit),
    .hit_data      (hit_data),
    .victim_valid  (victim_valid),
    .victim_dirty  (victim_dirty),
    .victim_addr   (victim_addr),
    .victim_data   (victim_data)
  );

endmodule

// ==== tests/dcache_tb.sv ====
// dcache_tb: clock, reset, sparse memory model, data file driver, checks and report

`timescale 1ns/1ps

module dcache_tb;

  logic                                clock;
  logic                                reset;
  logic                                req;
  dcache_pkg::req_op_t                 req_op;
  logic [dcache_pkg::addr_bits-1:0]    req_addr;
  logic [dcache_pkg::data_bits-1:0]    req_data;
  logic                                mem_rvalid = 1'b0;
  logic [dcache_pkg::data_bits-1:0]    mem_rdata = '0;
  logic                                busy;
  logic                                resp_valid;
  logic [dcache_pkg::data_bits-1:0]    resp_data;
  logic                                mem_rd;
  logic                                mem_wr;
  logic [dcache_pkg::addr_bits-1:0]    mem_addr;
  logic [dcache_pkg::data_bits-1:0]    mem_wdata;

  // memory model state, only addresses that were written are stored
  logic [dcache_pkg::data_bits-1:0]    mem_store [logic [dcache_pkg::addr_bits-1:0]];
  logic [dcache_pkg::addr_bits-1:0]    rd_addr_q = '0;
  int                                  rd_wait = 0;
  int                                  rd_count = 0;
  int                                  wr_count = 0;
  logic [dcache_pkg::addr_bits-1:0]    last_rd_addr = '0;
  logic [dcache_pkg::addr_bits-1:0]    last_wr_addr = '0;
  logic [dcache_pkg::data_bits-1:0]    last_wr_data = '0;

  // write-back expected during the next request
  logic                                wb_pending;
  logic [dcache_pkg::addr_bits-1:0]    wb_addr;
  logic [dcache_pkg::data_bits-1:0]    wb_data;

  int                                  pass_count;
  int                                  fail_count;
  bit                                  aborted;

  dcache_top i_dcache_top (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_data   (req_data),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata)
  );

  always #5 clock = ~clock;

  // power-on content of an address
  function automatic logic [63:0] initial_word(input logic [31:0] addr);
    return {addr, ~addr};
  endfunction

  function automatic logic [63:0] read_word(input logic [31:0] addr);
    if (mem_store.exists(addr)) begin
      return mem_store[addr];
    end
    return initial_word(addr);
  endfunction

  // memory: writes land at once, reads answer 1 to 6 cycles later
  initial begin
    // the delay draws come from this process
    void'($urandom(32'hd01d_4f51));
    forever begin
      @(posedge clock);
      mem_rvalid <= 1'b0;
      if (reset) begin
        rd_wait <= 0;
      end else begin
        if (mem_wr) begin
          mem_store[mem_addr] = mem_wdata;
          wr_count     <= wr_count + 1;
          last_wr_addr <= mem_addr;
          last_wr_data <= mem_wdata;
        end
        if (mem_rd) begin
          rd_count     <= rd_count + 1;
          last_rd_addr <= mem_addr;
          rd_addr_q    <= mem_addr;
          rd_wait      <= 1 + int'($urandom % 6);
        end else if (rd_wait == 1) begin
          mem_rvalid <= 1'b1;
          mem_rdata  <= read_word(rd_addr_q);
          rd_wait    <= 0;
        end else if (rd_wait > 1) begin
          rd_wait <= rd_wait - 1;
        end
      end
    end
  end

  // one request from strobe to response, then the memory traffic it caused
  task automatic run_request(input string name, input string op, input logic [31:0] addr,
                             input logic [63:0] data, input logic [63:0] expect_data);
    int errors;
    int cycles;
    int rd_before;
    int wr_before;
    int rd_expect;
    int wr_expect;
    bit is_load;
    bit is_hit;
    bit seen;
    errors    = 0;
    cycles    = 0;
    seen      = 1'b0;
    is_load   = (op == "LM") || (op == "LH");
    is_hit    = (op == "LH") || (op == "SH");
    rd_expect = (op == "LM") ? 1 : 0;
    wr_expect = wb_pending ? 1 : 0;
    @(posedge clock);
    if (busy) begin
      $display("%s: busy is high before the request", name);
      errors++;
    end
    rd_before = rd_count;
    wr_before = wr_count;
    req      <= 1'b1;
    req_op   <= is_load ? dcache_pkg::op_load : dcache_pkg::op_store;
    req_addr <= addr;
    req_data <= data;
    // accepting edge
    @(posedge clock);
    req <= 1'b0;
    while (!seen && cycles < 200) begin
      @(posedge clock);
      cycles++;
      seen = resp_valid;
    end
    if (!seen) begin
      $display("%s: no resp_valid within 200 cycles", name);
      aborted = 1'b1;
      errors++;
    end else begin
      if (is_load && resp_data !== expect_data) begin
        $display("error %s: resp_data expected %h actual %h", name, expect_data, resp_data);
        errors++;
      end
      if (is_hit && cycles != 2) begin
        $display("error %s: hit latency expected 2 actual %0d", name, cycles);
        errors++;
      end
      @(posedge clock);
      if (resp_valid) begin
        $display("%s: resp_valid lasted more than one cycle", name);
        errors++;
      end
      if (busy) begin
        $display("%s: busy stayed high after the response", name);
        errors++;
      end
      if (rd_count - rd_before != rd_expect) begin
        $display("error %s: mem_rd count expected %0d actual %0d",
                 name, rd_expect, rd_count - rd_before);
        errors++;
      end else if (rd_expect == 1 && last_rd_addr !== addr) begin
        $display("error %s: mem_rd address expected %h actual %h", name, addr, last_rd_addr);
        errors++;
      end
      if (wr_count - wr_before != wr_expect) begin
        $display("error %s: mem_wr count expected %0d actual %0d",
                 name, wr_expect, wr_count - wr_before);
        errors++;
      end else if (wr_expect == 1) begin
        if (last_wr_addr !== wb_addr) begin
          $display("error %s: mem_wr address expected %h actual %h",
                   name, wb_addr, last_wr_addr);
          errors++;
        end
        if (last_wr_data !== wb_data) begin
          $display("error %s: mem_wr data expected %h actual %h",
                   name, wb_data, last_wr_data);
          errors++;
        end
      end
    end
    wb_pending = 1'b0;
    if (errors == 0) begin
      pass_count++;
      $display("pass %s", name);
    end else begin
      fail_count++;
      $display("fail %s", name);
    end
  endtask

  initial begin
    int fd;
    int n;
    int errors;
    string line;
    string name;
    string op;
    logic [31:0] addr;
    logic [63:0] data;
    logic [63:0] expect_data;
    clock       = 1'b0;
    reset       = 1'b1;
    req         = 1'b0;
    req_op      = dcache_pkg::op_load;
    req_addr    = '0;
    req_data    = '0;
    wb_pending  = 1'b0;
    wb_addr     = '0;
    wb_data     = '0;
    pass_count  = 0;
    fail_count  = 0;
    aborted     = 1'b0;
    errors      = 0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    // idle outputs straight out of reset
    if (busy || resp_valid || mem_rd || mem_wr) begin
      $display("after_reset: busy, resp_valid, mem_rd or mem_wr is high after reset");
      errors++;
    end
    if (errors == 0) begin
      pass_count++;
      $display("pass after_reset");
    end else begin
      fail_count++;
      $display("fail after_reset");
    end
    fd = $fopen("tests/dcache_input.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/dcache_input.txt");
      aborted = 1'b1;
    end else begin
      while (!aborted && $fgets(line, fd) > 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, expect_data);
          if (n != 5) begin
            $display("malformed line in the data file: %s", line);
            fail_count++;
          end else if (op == "WB") begin
            wb_pending = 1'b1;
            wb_addr    = addr;
            wb_data    = data;
          end else if (op == "LM" || op == "LH" || op == "SM" || op == "SH") begin
            run_request(name, op, addr, data, expect_data);
          end else begin
            $display("unknown operation %s on data file line %s", op, name);
            fail_count++;
          end
        end
      end
      $fclose(fd);
    end
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && !aborted) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
source/dcache_pkg.sv
source/dcache_way.sv
source/dcache_array.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tests/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal -j 0
TOP       = dcache_tb
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/dcache_input.txt ====
# name op addr data expect (LM/LH load miss/hit, SM/SH store miss/hit, WB = next mem_wr)
# memory starts as {addr, ~addr}, all values hex, set is addr[5:3], tag is addr[31:6]
cold_ld_a      LM 00000000 0000000000000000 00000000ffffffff
hit_ld_a       LH 00000000 0000000000000000 00000000ffffffff
st_hit_a       SH 00000000 1111111111111111 0000000000000000
ld_after_st_a  LH 00000000 0000000000000000 1111111111111111
cold_ld_b      LM 00000040 0000000000000000 00000040ffffffbf
st_miss_c      SM 00000080 2222222222222222 0000000000000000
ld_c_resident  LH 00000080 0000000000000000 2222222222222222
cold_ld_d      LM 000000c0 0000000000000000 000000c0ffffff3f
wb_a           WB 00000000 1111111111111111 0000000000000000
ld_e_evict_a   LM 00000100 0000000000000000 00000100fffffeff
ld_a_refetch   LM 00000000 0000000000000000 1111111111111111
wb_c           WB 00000080 2222222222222222 0000000000000000
ld_b_evict_c   LM 00000040 0000000000000000 00000040ffffffbf
ld_c_refetch   LM 00000080 0000000000000000 2222222222222222
st_hit_a2      SH 00000000 3333333333333333 0000000000000000
ld_e_hit       LH 00000100 0000000000000000 00000100fffffeff
st_miss_s1     SM 00000008 4444444444444444 0000000000000000
ld_s1          LH 00000008 0000000000000000 4444444444444444
st_hit_s1      SH 00000008 5555555555555555 0000000000000000
ld_s1_new      LH 00000008 0000000000000000 5555555555555555
ld_f_evict_e   LM 00000140 0000000000000000 00000140fffffebf
wb_a2          WB 00000000 3333333333333333 0000000000000000
ld_g_evict_a   LM 00000180 0000000000000000 00000180fffffe7f
ld_a_final     LM 00000000 0000000000000000 3333333333333333
st_hit_c       SH 00000080 7777777777777777 0000000000000000
wb_c2          WB 00000080 7777777777777777 0000000000000000
st_miss_h      SM 000001c0 6666666666666666 0000000000000000
ld_h           LH 000001c0 0000000000000000 6666666666666666
ld_c_final     LM 00000080 0000000000000000 7777777777777777
